// ==== project.f ====
+incdir+rtl
rtl/spr_pkg.sv
rtl/spr_if.sv
rtl/table_store.sv
rtl/column_sequencer.sv
rtl/line_buffer.sv
rtl/pixel_colour.sv
rtl/column_render_top.sv
tb/render_props.sv
tb/tb_checker.sv
tb/tb_top.sv

// ==== run.sh ====
#!/bin/sh
# compile with Verilator, run, and search the output for the pass message
verilator --binary --timing --assert --top-module tb_top -f project.f \
    && ./obj_dir/Vtb_top | tee /dev/stderr | grep -q "Test completed successfully" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== tb/tb_top.sv ====
//============================
// testbench top
// clock, reset, LFSR stimulus,
// table download, ROM responder,
// line requests, watchdog
//============================
`timescale 1ns/1ps
`include "spr_defs.svh"

module tb_top;

    localparam int LOAD_BYTES  = 11392;
    localparam int TILE_BYTES  = 6144;
    localparam int LINES       = 4;
    localparam int LINE_CYCLES = 4000;
    localparam int READS       = 5;
    localparam int WATCHDOG_NS = 4 * (LOAD_BYTES + 2 * TILE_BYTES + LINES * LINE_CYCLES
                                      + READS * 300 + 100);

    logic                      clk_sys = 1'b0;
    logic                      reset;
    logic                      load_wr;
    logic [13:0]               load_addr;
    logic [7:0]                load_data;
    logic                      line_req;
    logic [7:0]                line_num;
    logic                      line_ack;
    logic                      rom_req;
    logic [`SPR_ROM_ABITS-1:0] rom_addr;
    logic                      rom_ack;
    logic [15:0]               rom_data;
    logic                      pix_en;
    logic                      pix_bank;
    logic [7:0]                pix_x;
    logic [23:0]               rgb;
    logic                      rgb_valid;
    logic [31:0]               lfsr = 32'h8a8b;
    int                        pix_mark = 0;
    int                        err_mark = 0;
    int                        total;

    always #2 clk_sys = ~clk_sys;

    column_render_top uut (.*);

    tb_checker chk (.*);

    // galois LFSR, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic logic [15:0] rom_word(input logic [9:0] a);
        logic [15:0] v;
        v = {6'd0, a} * 16'h9e37;
        return v ^ {a[5:0], a} ^ 16'h5ac3;
    endfunction

    task automatic load_byte(input logic [13:0] a, input logic [7:0] d);
        @(posedge clk_sys);
        #1;
        load_wr   = 1'b1;
        load_addr = a;
        load_data = d;
    endtask

    task automatic load_all();
        for (int a = 0; a < LOAD_BYTES; a++) begin
            load_byte(14'(a), 8'(rand_bits(8)));
        end
        @(posedge clk_sys);
        #1 load_wr = 1'b0;
    endtask

    // tile entries of groups 1 to 3 with flip_y forced
    task automatic load_tiles(input logic flip);
        logic [7:0] hi;
        for (int w = 1024; w < 4096; w++) begin
            load_byte(14'(2 * w), 8'(rand_bits(8)));
            hi    = 8'(rand_bits(8));
            hi[6] = flip;
            load_byte(14'(2 * w + 1), hi);
        end
        @(posedge clk_sys);
        #1 load_wr = 1'b0;
    endtask

    task automatic render_line(input logic [7:0] n);
        @(posedge clk_sys);
        #1;
        line_num = n;
        line_req = 1'b1;
        do @(posedge clk_sys); while (!line_ack);
        #1 line_req = 1'b0;
        do @(posedge clk_sys); while (line_ack);
    endtask

    task automatic read_line(input logic bank);
        for (int x = 0; x < 256; x++) begin
            @(posedge clk_sys);
            #1;
            pix_en   = 1'b1;
            pix_bank = bank;
            pix_x    = 8'(x);
        end
        @(posedge clk_sys);
        #1 pix_en = 1'b0;
        // fixed readout latency of three cycles
        repeat (4) @(posedge clk_sys);
    endtask

    task automatic report(input string name);
        $display("%-30s pixels %0d errors %0d", name,
                 chk.pix_count - pix_mark, chk.err_count - err_mark);
        pix_mark = chk.pix_count;
        err_mark = chk.err_count;
    endtask

    //============================
    // ROM responder
    //============================
    initial begin
        int wait_n;
        int hold_n;
        rom_ack  = 1'b0;
        rom_data = '0;
        forever begin
            @(posedge clk_sys);
            if (rom_req && !rom_ack) begin
                wait_n = int'(rand_bits(2));
                repeat (wait_n) @(posedge clk_sys);
                #1;
                rom_data = rom_word(rom_addr);
                rom_ack  = 1'b1;
                do @(posedge clk_sys); while (rom_req);
                // late ack release stalls the next fetch
                hold_n = int'(rand_bits(3));
                repeat (hold_n) @(posedge clk_sys);
                #1 rom_ack = 1'b0;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        $display("Test failed");
        $finish;
    end

    //============================
    // test sequence
    //============================
    initial begin
        reset     = 1'b1;
        load_wr   = 1'b0;
        load_addr = '0;
        load_data = '0;
        line_req  = 1'b0;
        line_num  = '0;
        pix_en    = 1'b0;
        pix_bank  = 1'b0;
        pix_x     = '0;
        repeat (16) @(posedge clk_sys);
        #1 reset = 1'b0;

        load_all();
        report("random table load");
        render_line(8'd10);
        read_line(1'b0);
        report("line 10 readout");
        // old bank read while the next line renders
        fork
            render_line(8'd11);
            read_line(1'b0);
        join
        read_line(1'b1);
        report("line 11 with bank 0 readout");
        load_tiles(1'b1);
        render_line(8'd20);
        read_line(1'b0);
        report("flip_y set, line 20");
        load_tiles(1'b0);
        render_line(8'd37);
        read_line(1'b1);
        report("flip_y clear, line 37");

        total = chk.err_count + uut.u_seq.props.fail_count;
        $display("checked %0d pixels, %0d errors", chk.pix_count, total);
        if (total == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== tb/tb_checker.sv ====
//============================
// testbench checker
// download mirror, render model,
// rgb comparison and counters
//============================
`timescale 1ns/1ps
`include "spr_defs.svh"

module tb_checker (
    input logic        clk_sys,
    input logic        reset,
    input logic        load_wr,
    input logic [13:0] load_addr,
    input logic [7:0]  load_data,
    input logic        line_req,
    input logic [7:0]  line_num,
    input logic        line_ack,
    input logic        rom_req,
    input logic        pix_en,
    input logic        pix_bank,
    input logic [7:0]  pix_x,
    input logic [23:0] rgb,
    input logic        rgb_valid
);

    int          err_count = 0;
    int          pix_count = 0;
    int          cycle = 0;
    logic        ack_q = 1'b0;
    logic        seen_req = 1'b0;
    // raw download image and model line buffer {colour, pen}
    logic [7:0]  img [0:16383];
    logic [11:0] mdl [0:511];
    logic [23:0] exp_q [$];
    int          cyc_q [$];

    function automatic logic [15:0] rom_word(input logic [9:0] a);
        logic [15:0] v;
        v = {6'd0, a} * 16'h9e37;
        return v ^ {a[5:0], a} ^ 16'h5ac3;
    endfunction

    function automatic logic [15:0] spr_word(input logic [11:0] w);
        logic [13:0] a;
        a = `SPR_LOAD_SPRRAM + {1'b0, w, 1'b0};
        return {img[a + 14'd1], img[a]};
    endfunction

    function automatic logic [7:0] clut_entry(input logic [9:0] c);
        logic [13:0] a;
        a = `SPR_LOAD_CLUT + {3'd0, c, 1'b0};
        return {img[a + 14'd1][3:0], img[a][3:0]};
    endfunction

    function automatic logic [11:0] pal_entry(input logic [7:0] p);
        logic [13:0] a;
        a = `SPR_LOAD_PAL + {4'd0, p, 2'b00};
        return {img[a][3:0], img[a + 14'd1][3:0], img[a + 14'd2][3:0]};
    endfunction

    //============================
    // render model
    //============================
    task automatic render_model(input logic [7:0] line);
        logic [1:0]  grp;
        logic [15:0] pos;
        logic [15:0] ent;
        logic [15:0] w;
        logic [7:0]  idx;
        logic [7:0]  colour;
        logic [2:0]  row;
        logic [1:0]  b;
        logic [3:0]  pen;
        for (int x = 0; x < 256; x++) begin
            mdl[{line[0], x[7:0]}] = '0;
        end
        for (int layer = 0; layer < 3; layer++) begin
            grp = (layer == 0) ? 2'd2 : (layer == 1) ? 2'd3 : 2'd1;
            for (int col = 0; col < 32; col++) begin
                pos    = spr_word({2'b00, col[4:0], 3'b000, grp});
                idx    = line - (8'd1 - pos[15:8]);
                ent    = spr_word({grp, col[4:0], idx[7:3]});
                colour = img[`SPR_LOAD_TILECOL + {7'd0, ent[5:0], ent[15]}];
                row    = ent[14] ? ~idx[2:0] : idx[2:0];
                for (int o = 0; o < 8; o++) begin
                    w   = rom_word({ent[5:0], ~o[2], row});
                    b   = o[1:0];
                    pen = {w[{2'b01, b}], w[{2'b00, b}], w[{2'b11, b}], w[{2'b10, b}]};
                    if (pen != 4'd0) begin
                        mdl[{line[0], pos[7:0] + {5'd0, o[2:0]}}] = {colour, pen};
                    end
                end
            end
        end
    endtask

    always @(posedge clk_sys) begin
        logic [11:0] e;
        logic [11:0] p;
        logic [23:0] exp_rgb;
        cycle++;
        ack_q <= line_ack;
        if (load_wr) begin
            img[load_addr] = load_data;
        end
        if (line_req) begin
            seen_req <= 1'b1;
        end
        if (!reset && !seen_req && (line_ack || rom_req || rgb_valid)) begin
            err_count++;
            $display("outputs became active before the first line request");
        end
        if (line_ack && !ack_q) begin
            if (!line_req) begin
                err_count++;
                $display("line_ack rose while line_req was low");
            end
            render_model(line_num);
        end
        if (rgb_valid) begin
            if (exp_q.size() == 0) begin
                err_count++;
                $display("rgb_valid high with no pixel requested");
            end else begin
                if (cycle - cyc_q[0] != 3) begin
                    err_count++;
                    $display("rgb arrived %0d cycles after pix_en instead of 3",
                             cycle - cyc_q[0]);
                end
                if (rgb !== exp_q[0]) begin
                    err_count++;
                    $display("Fail rgb expected %h got %h", exp_q[0], rgb);
                end
                pix_count++;
                void'(exp_q.pop_front());
                void'(cyc_q.pop_front());
            end
        end
        if (pix_en) begin
            e = mdl[{pix_bank, pix_x}];
            if (e[3:0] == 4'd0) begin
                exp_rgb = '0;
            end else begin
                p = pal_entry(clut_entry({e[9:4], e[3:0]}));
                exp_rgb = {p[11:8], p[11:8], p[7:4], p[7:4], p[3:0], p[3:0]};
            end
            exp_q.push_back(exp_rgb);
            cyc_q.push_back(cycle);
        end
    end

endmodule

// ==== tb/render_props.sv ====
//============================
// sequencer assertions
// line and ROM handshakes,
// reset state
//============================
`timescale 1ns/1ps
`include "spr_defs.svh"

module render_props (
    input logic                      clk_sys,
    input logic                      reset,
    input logic                      line_req,
    input logic                      line_ack,
    input logic                      rom_req,
    input logic [`SPR_ROM_ABITS-1:0] rom_addr,
    input logic                      rom_ack
);

    int fail_count = 0;

    // ack only answers a pending request
    ack_needs_req: assert property (@(posedge clk_sys) disable iff (reset)
        $rose(line_ack) |-> line_req)
        else begin fail_count++; $error("line_ack rose without line_req"); end

    // address held until the responder acks
    rom_addr_held: assert property (@(posedge clk_sys) disable iff (reset)
        rom_req && !rom_ack |=> rom_req && $stable(rom_addr))
        else begin fail_count++; $error("rom_req dropped or rom_addr moved"); end

    rom_new_req: assert property (@(posedge clk_sys) disable iff (reset)
        $rose(rom_req) |-> !rom_ack)
        else begin fail_count++; $error("rom_req raised while rom_ack high"); end

    reset_quiet: assert property (@(posedge clk_sys)
        reset |=> !line_ack && !rom_req)
        else begin fail_count++; $error("handshake outputs high after reset"); end

endmodule

bind column_sequencer render_props props (
    .clk_sys, .reset, .line_req, .line_ack, .rom_req, .rom_addr, .rom_ack
);

// ==== rtl/column_render_top.sv ====
//============================
// sprite column renderer top
// tables, sequencer, line buffer
// and colour readout
//============================
`timescale 1ns/1ps
`include "spr_defs.svh"

module column_render_top import spr_pkg::*; (
    input  logic                      clk_sys,
    input  logic                      reset,
    // table download
    input  logic                      load_wr,
    input  logic [13:0]               load_addr,
    input  logic [7:0]                load_data,
    // line request
    input  logic                      line_req,
    input  logic [7:0]                line_num,
    output logic                      line_ack,
    // graphics ROM
    output logic                      rom_req,
    output logic [`SPR_ROM_ABITS-1:0] rom_addr,
    input  logic                      rom_ack,
    input  logic [15:0]               rom_data,
    // readout
    input  logic                      pix_en,
    input  logic                      pix_bank,
    input  logic [7:0]                pix_x,
    output logic [23:0]               rgb,
    output logic                      rgb_valid
);

    render_tables_if render_bus ();
    colour_tables_if colour_bus ();
    lbuf_wr_if       lbuf_bus ();

    logic        lbuf_bank;
    logic [7:0]  lbuf_x;
    lbuf_entry_t lbuf_data;

    table_store u_tables (
        .clk_sys, .reset, .load_wr, .load_addr, .load_data,
        .render (render_bus),
        .colour (colour_bus)
    );

    column_sequencer u_seq (
        .clk_sys, .reset, .line_req, .line_num, .line_ack,
        .rom_req, .rom_addr, .rom_ack, .rom_data,
        .tables (render_bus),
        .lbuf   (lbuf_bus)
    );

    line_buffer u_lbuf (
        .clk_sys,
        .wr      (lbuf_bus),
        .rd_bank (lbuf_bank),
        .rd_x    (lbuf_x),
        .rd_data (lbuf_data)
    );

    pixel_colour u_colour (
        .clk_sys, .reset, .pix_en, .pix_bank, .pix_x,
        .lbuf_bank, .lbuf_x, .lbuf_data,
        .tables (colour_bus),
        .rgb, .rgb_valid
    );

endmodule

// ==== rtl/pixel_colour.sv ====
//============================
// pixel colour readout
// line buffer, CLUT and palette
// stages to 24-bit rgb
//============================
`timescale 1ns/1ps

module pixel_colour import spr_pkg::*; (
    input  logic        clk_sys,
    input  logic        reset,
    input  logic        pix_en,
    input  logic        pix_bank,
    input  logic [7:0]  pix_x,
    output logic        lbuf_bank,
    output logic [7:0]  lbuf_x,
    input  lbuf_entry_t lbuf_data,
    colour_tables_if.rd tables,
    output rgb_t        rgb,
    output logic        rgb_valid
);

    logic       rd_valid;
    logic       clut_valid;
    logic [3:0] clut_pen;
    logic [3:0] pal_pen;

    // stage 1 line buffer read
    assign lbuf_bank = pix_bank;
    assign lbuf_x    = pix_x;

    // stage 2 clut at colour and pen
    assign tables.clut_addr = {lbuf_data.colour[5:0], lbuf_data.pen};

    // stage 3 palette
    assign tables.pal_addr = tables.clut_data;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            rd_valid   <= 1'b0;
            clut_valid <= 1'b0;
            rgb_valid  <= 1'b0;
        end else begin
            rd_valid   <= pix_en;
            clut_valid <= rd_valid;
            rgb_valid  <= clut_valid;
        end
    end

    // pen follows the pixel for the transparency test
    always_ff @(posedge clk_sys) begin
        clut_pen <= lbuf_data.pen;
        pal_pen  <= clut_pen;
    end

    // nibble doubling, uncovered pixels black
    always_comb begin
        if (pal_pen == 4'd0) begin
            rgb = '0;
        end else begin
            rgb.r = {2{tables.pal_data[11:8]}};
            rgb.g = {2{tables.pal_data[7:4]}};
            rgb.b = {2{tables.pal_data[3:0]}};
        end
    end

endmodule

// ==== rtl/line_buffer.sv ====
//============================
// line buffer
// two banks of one line each,
// write port and sync read port
//============================
`timescale 1ns/1ps
`include "spr_defs.svh"

module line_buffer import spr_pkg::*; (
    input  logic        clk_sys,
    lbuf_wr_if.dst      wr,
    input  logic        rd_bank,
    input  logic [7:0]  rd_x,
    output lbuf_entry_t rd_data
);

    // bank is the top address bit
    lbuf_entry_t mem [0:2*`SPR_LINE_W-1];

    always_ff @(posedge clk_sys) begin
        if (wr.wr_en) begin
            mem[{wr.wr_bank, wr.wr_x}] <= wr.wr_data;
        end
        rd_data <= mem[{rd_bank, rd_x}];
    end

endmodule

// ==== rtl/column_sequencer.sv ====
//============================
// column sequencer
// line request handshake, bank clear,
// layer and column walk, bitmap
// fetch, pen writes
//============================
`timescale 1ns/1ps
`include "spr_defs.svh"

module column_sequencer import spr_pkg::*; (
    input  logic                      clk_sys,
    input  logic                      reset,
    input  logic                      line_req,
    input  logic [7:0]                line_num,
    output logic                      line_ack,
    output logic                      rom_req,
    output logic [`SPR_ROM_ABITS-1:0] rom_addr,
    input  logic                      rom_ack,
    input  logic [15:0]               rom_data,
    render_tables_if.seq              tables,
    lbuf_wr_if.src                    lbuf
);

    typedef enum logic [3:0] {
        st_idle, st_clear, st_pos, st_idx, st_tile, st_rom, st_rom_wait, st_pen, st_ack
    } state_t;

    state_t                    state;
    logic [7:0]                clr_x;
    logic [1:0]                layer;
    logic [4:0]                col;
    logic [2:0]                ofs;
    logic [1:0]                spr_group;
    logic [7:0]                idx_now;
    logic [7:0]                col_x;
    logic [2:0]                row_idx;
    logic [`SPR_TILE_BITS-1:0] tile_q;
    logic                      flip_q;
    logic                      bank_q;
    logic [15:0]               pix_bits;
    logic [3:0]                pen;

    // layer walk order 2, 3, 1
    assign spr_group = (layer == 2'd0) ? 2'd2 : (layer == 2'd1) ? 2'd3 : 2'd1;

    // row of the column that meets this line
    assign idx_now = line_num - (8'd1 - tables.spr_word.pos.y);

    // position word in st_pos, tile entry otherwise
    assign tables.spr_addr = (state == st_pos) ? {2'b00, col, 3'b000, spr_group}
                                               : {spr_group, col, idx_now[7:3]};
    assign tables.tcol_addr = {tile_q, bank_q};

    // four bitplanes, msb first
    assign pen = {pix_bits[4 + ofs[1:0]], pix_bits[ofs[1:0]],
                  pix_bits[12 + ofs[1:0]], pix_bits[8 + ofs[1:0]]};

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            state      <= st_idle;
            line_ack   <= 1'b0;
            rom_req    <= 1'b0;
            lbuf.wr_en <= 1'b0;
            clr_x      <= '0;
            layer      <= '0;
            col        <= '0;
            ofs        <= '0;
        end else begin
            lbuf.wr_en <= 1'b0;
            case (state)
                st_idle: begin
                    if (line_req) begin
                        clr_x <= '0;
                        layer <= '0;
                        col   <= '0;
                        ofs   <= '0;
                        state <= st_clear;
                    end
                end
                st_clear: begin
                    lbuf.wr_en   <= 1'b1;
                    lbuf.wr_bank <= line_num[0];
                    lbuf.wr_x    <= clr_x;
                    lbuf.wr_data <= '0;
                    clr_x        <= clr_x + 8'd1;
                    if (clr_x == 8'(`SPR_LINE_W - 1)) begin
                        state <= st_pos;
                    end
                end
                st_pos: state <= st_idx;
                st_idx: begin
                    col_x   <= tables.spr_word.pos.x;
                    row_idx <= idx_now[2:0];
                    state   <= st_tile;
                end
                st_tile: begin
                    tile_q <= tables.spr_word.tile.tile[`SPR_TILE_BITS-1:0];
                    flip_q <= tables.spr_word.tile.flip_y;
                    bank_q <= tables.spr_word.tile.bank;
                    state  <= st_rom;
                end
                st_rom: begin
                    // previous ack must be gone first
                    if (!rom_ack) begin
                        rom_req  <= 1'b1;
                        rom_addr <= {tile_q, ~ofs[2], flip_q ? ~row_idx : row_idx};
                        state    <= st_rom_wait;
                    end
                end
                st_rom_wait: begin
                    if (rom_ack) begin
                        rom_req  <= 1'b0;
                        pix_bits <= rom_data;
                        state    <= st_pen;
                    end
                end
                st_pen: begin
                    lbuf.wr_en   <= (pen != 4'd0);
                    lbuf.wr_bank <= line_num[0];
                    lbuf.wr_x    <= col_x + {5'd0, ofs};
                    lbuf.wr_data <= '{colour: tables.tcol_data, pen: pen};
                    ofs          <= ofs + 3'd1;
                    if (ofs == 3'd3) begin
                        state <= st_rom;
                    end else if (ofs == 3'd7) begin
                        col <= col + 5'd1;
                        if (col != 5'(`SPR_COLS - 1)) begin
                            state <= st_pos;
                        end else if (layer != 2'(`SPR_LAYERS - 1)) begin
                            layer <= layer + 2'd1;
                            state <= st_pos;
                        end else begin
                            line_ack <= 1'b1;
                            state    <= st_ack;
                        end
                    end
                end
                st_ack: begin
                    if (!line_req) begin
                        line_ack <= 1'b0;
                        state    <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

// ==== rtl/table_store.sv ====
//============================
// table store
// download decode, sprite RAM,
// tile colours, CLUT, palette
//============================
`timescale 1ns/1ps
`include "spr_defs.svh"

module table_store import spr_pkg::*; (
    input  logic           clk_sys,
    input  logic           reset,
    input  logic           load_wr,
    input  logic [13:0]    load_addr,
    input  logic [7:0]     load_data,
    render_tables_if.store render,
    colour_tables_if.store colour
);

    spr_word_t   spr_ram  [0:(1 << `SPR_RAM_ABITS)-1];
    logic [7:0]  tcol_ram [0:(1 << `SPR_TCOL_ABITS)-1];
    logic [7:0]  clut_ram [0:(1 << `SPR_CLUT_ABITS)-1];
    logic [11:0] pal_ram  [0:(1 << `SPR_PAL_ABITS)-1];

    // download byte, registered once
    logic        ld_wr;
    logic [13:0] ld_addr;
    logic [7:0]  ld_data;

    // partial entries while bytes arrive
    logic [7:0]  spr_lo;
    logic [3:0]  clut_lo;
    logic [7:0]  pal_rg;

    logic [13:0] spr_ofs;
    logic [13:0] tcol_ofs;
    logic [13:0] clut_ofs;
    logic [13:0] pal_ofs;

    assign spr_ofs  = ld_addr - `SPR_LOAD_SPRRAM;
    assign tcol_ofs = ld_addr - `SPR_LOAD_TILECOL;
    assign clut_ofs = ld_addr - `SPR_LOAD_CLUT;
    assign pal_ofs  = ld_addr - `SPR_LOAD_PAL;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            ld_wr <= 1'b0;
        end else begin
            ld_wr <= load_wr;
        end
        ld_addr <= load_addr;
        ld_data <= load_data;
    end

    //============================
    // download decode
    //============================
    always_ff @(posedge clk_sys) begin
        if (ld_wr && ld_addr < `SPR_LOAD_TILECOL) begin
            // low byte first
            if (!spr_ofs[0]) begin
                spr_lo <= ld_data;
            end else begin
                spr_ram[spr_ofs[`SPR_RAM_ABITS:1]] <= {ld_data, spr_lo};
            end
        end
        if (ld_wr && ld_addr >= `SPR_LOAD_TILECOL && ld_addr < `SPR_LOAD_CLUT) begin
            tcol_ram[tcol_ofs[`SPR_TCOL_ABITS-1:0]] <= ld_data;
        end
        if (ld_wr && ld_addr >= `SPR_LOAD_CLUT && ld_addr < `SPR_LOAD_PAL) begin
            if (!clut_ofs[0]) begin
                clut_lo <= ld_data[3:0];
            end else begin
                clut_ram[clut_ofs[`SPR_CLUT_ABITS:1]] <= {ld_data[3:0], clut_lo};
            end
        end
        if (ld_wr && ld_addr >= `SPR_LOAD_PAL && ld_addr < `SPR_LOAD_END) begin
            // r, g, b low nibbles, fourth byte unused
            case (pal_ofs[1:0])
                2'd0: pal_rg[7:4] <= ld_data[3:0];
                2'd1: pal_rg[3:0] <= ld_data[3:0];
                2'd2: pal_ram[pal_ofs[`SPR_PAL_ABITS+1:2]] <= {pal_rg, ld_data[3:0]};
                default: ;
            endcase
        end
    end

    //============================
    // read ports
    //============================
    always_ff @(posedge clk_sys) begin
        render.spr_word  <= spr_ram[render.spr_addr];
        render.tcol_data <= tcol_ram[render.tcol_addr];
        colour.clut_data <= clut_ram[colour.clut_addr];
        colour.pal_data  <= pal_ram[colour.pal_addr];
    end

endmodule

// ==== rtl/spr_if.sv ====
//============================
// renderer interfaces
// render table reads, colour table
// reads, line buffer writes
//============================
`timescale 1ns/1ps
`include "spr_defs.svh"

// sprite RAM and tile colour reads, one clock latency
interface render_tables_if import spr_pkg::*; ();
    logic [`SPR_RAM_ABITS-1:0]  spr_addr;
    logic [`SPR_TCOL_ABITS-1:0] tcol_addr;
    spr_word_t                  spr_word;
    logic [7:0]                 tcol_data;

    modport seq   (output spr_addr, output tcol_addr, input spr_word, input tcol_data);
    modport store (input spr_addr, input tcol_addr, output spr_word, output tcol_data);
endinterface

// clut and palette reads, one clock latency
interface colour_tables_if ();
    logic [`SPR_CLUT_ABITS-1:0] clut_addr;
    logic [`SPR_PAL_ABITS-1:0]  pal_addr;
    logic [7:0]                 clut_data;
    logic [11:0]                pal_data;

    modport rd    (output clut_addr, output pal_addr, input clut_data, input pal_data);
    modport store (input clut_addr, input pal_addr, output clut_data, output pal_data);
endinterface

// line buffer write port
interface lbuf_wr_if import spr_pkg::*; ();
    logic        wr_en;
    logic        wr_bank;
    logic [7:0]  wr_x;
    lbuf_entry_t wr_data;

    modport src (output wr_en, output wr_bank, output wr_x, output wr_data);
    modport dst (input wr_en, input wr_bank, input wr_x, input wr_data);
endinterface

// ==== rtl/spr_pkg.sv ====
//============================
// sprite renderer types
// sprite RAM word union,
// line buffer entry, rgb pixel
//============================
package spr_pkg;

    // position view of a sprite RAM word
    typedef struct packed {
        logic [7:0] y;
        logic [7:0] x;
    } spr_pos_t;

    // tile entry view, bank selects the colour half
    typedef struct packed {
        logic        bank;
        logic        flip_y;
        logic [13:0] tile;
    } spr_tile_t;

    typedef union packed {
        spr_pos_t  pos;
        spr_tile_t tile;
    } spr_word_t;

    // pen zero means transparent
    typedef struct packed {
        logic [7:0] colour;
        logic [3:0] pen;
    } lbuf_entry_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

endpackage

// ==== rtl/spr_defs.svh ====
//============================
// sprite renderer defines
// field widths, layer geometry,
// table sizes and download byte map
//============================
`ifndef SPR_DEFS_SVH
`define SPR_DEFS_SVH

// field widths
`define SPR_TILE_BITS    6
`define SPR_RAM_ABITS    12
`define SPR_ROM_ABITS    (`SPR_TILE_BITS + 4)

// layer geometry
`define SPR_LAYERS       3
`define SPR_COLS         32
`define SPR_LINE_W       256

// table address widths
`define SPR_TCOL_ABITS   (`SPR_TILE_BITS + 1)
`define SPR_CLUT_ABITS   10
`define SPR_PAL_ABITS    8

// download regions, byte addresses
`define SPR_LOAD_SPRRAM  14'h0000
`define SPR_LOAD_TILECOL 14'h2000
`define SPR_LOAD_CLUT    14'h2080
`define SPR_LOAD_PAL     14'h2880
`define SPR_LOAD_END     14'h2C80

`endif
